// File: hw/cramPkg.sv
package cramPkg;

  ////////////////////////////////////////////////////////////
  // Microword and address geometry
  ////////////////////////////////////////////////////////////

  localparam int adrWidth = 11;
  localparam int dispWidth = 5;
  localparam int condWidth = 6;

  // Reduced data path sources feeding the dispatch term
  localparam int dramAWidth = 3;
  localparam int srcWidth = 4;
  localparam int condFlagWidth = 8;

  // Subroutine stack
  localparam int stackDepth = 16;
  localparam int stackPtrWidth = 4;

  typedef logic [adrWidth-1:0] cradrT;

  // Each DISP group code is the top value of its group
  localparam logic [dispWidth-1:0] dispGrp03 = 5'o03;
  localparam logic [dispWidth-1:0] dispGrp07 = 5'o07;
  localparam logic [dispWidth-1:0] dispGrp37 = 5'o37;

  // Upper three COND bits of the skip groups
  localparam logic [2:0] skipGrp40 = 3'o4;
  localparam logic [2:0] skipGrp50 = 3'o5;

  localparam cradrT force1777Adr = {adrWidth{1'b1}};

  // DISP 00-03, high part of the address
  function automatic logic isGrp03(input logic [dispWidth-1:0] disp);
    return (disp | 5'o03) == dispGrp03;
  endfunction

  // DISP 00-07, address bits 3..0
  function automatic logic isGrp07(input logic [dispWidth-1:0] disp);
    return (disp | 5'o07) == dispGrp07;
  endfunction

  // DISP 30-37, condition dispatch
  function automatic logic isGrp37(input logic [dispWidth-1:0] disp);
    return (disp | 5'o07) == dispGrp37;
  endfunction

endpackage

// File: hw/ebusPkg.sv
package ebusPkg;

  ////////////////////////////////////////////////////////////
  // Diagnostic bus slice
  ////////////////////////////////////////////////////////////

  localparam int ebusWidth = 6;
  localparam int diagStrobeWidth = 2;

  typedef logic [2:0] diagFuncT;
  typedef logic [diagStrobeWidth-1:0] diagStrobeT;

  // Load strobes for the two halves of the diagnostic address
  localparam diagStrobeT diagLoadLow = 2'b01;
  localparam diagStrobeT diagLoadHigh = 2'b10;

  // Readback word select
  localparam diagFuncT diagRdDecode = 3'd0;
  localparam diagFuncT diagRdCall = 3'd1;
  localparam diagFuncT diagRdRetLow = 3'd2;
  localparam diagFuncT diagRdRetHigh = 3'd3;
  localparam diagFuncT diagRdAdrLow = 3'd4;
  localparam diagFuncT diagRdParity = 3'd5;
  localparam diagFuncT diagRdAdrLowAlt = 3'd6;
  localparam diagFuncT diagRdAdrHigh = 3'd7;

endpackage

// File: hw/iCramWord.sv
`timescale 1ns/1ps

// Decoded microword fields of the address section.
// Driven from the top level, one value per cycle.
interface iCramWord;

  // Jump field, ORed straight into the next address
  cramPkg::cradrT j;

  // Dispatch select
  logic [cramPkg::dispWidth-1:0] disp;

  // Skip condition select
  logic [cramPkg::condWidth-1:0] cond;

  // Subroutine call
  logic call;

  ////////////////////////////////////////////////////////////
  // Views
  ////////////////////////////////////////////////////////////

  // Next address logic sees the whole word
  modport dispatch (
    input j,
    input disp,
    input cond,
    input call
  );

  // Stack only looks at call and dispatch
  modport stack (
    input call,
    input disp
  );

  // Readback of the dispatch decode
  modport diag (
    input call,
    input disp
  );

endinterface

// File: hw/craDispatch.sv
`timescale 1ns/1ps

module craDispatch (
  input  logic                                  eboxClk,
  input  logic                                  rstN,
  iCramWord.dispatch                            cw,
  input  logic                                  force1777,
  input  logic [cramPkg::dramAWidth-1:0]        dramA,
  input  cramPkg::cradrT                        dramJ,
  input  logic [cramPkg::srcWidth-1:0]          pfDisp,
  input  logic [cramPkg::srcWidth-1:0]          sr,
  input  logic [cramPkg::srcWidth-1:0]          niCond,
  input  logic [cramPkg::srcWidth-1:0]          shmSh,
  input  logic [cramPkg::condFlagWidth-1:0]     condFlags,
  input  cramPkg::cradrT                        diagAdr,
  input  cramPkg::cradrT                        sbrRet,
  output cramPkg::cradrT                        cradr,
  output logic                                  returnStrobe,
  output logic                                  dispParity
);

  logic grp03En;
  logic grp07En;
  logic grp37En;
  logic skip40En;
  logic skip50En;
  logic [2:0] condSel;
  logic [cramPkg::adrWidth-1:cramPkg::srcWidth] hiTerm;
  logic [cramPkg::srcWidth-1:0] loTerm;
  logic skipBit;
  logic [2*cramPkg::condFlagWidth-1:0] condFlagsWrap;
  cramPkg::cradrT forceTerm;
  cramPkg::cradrT dispTerm;

  ////////////////////////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////////////////////////

  assign grp03En = cramPkg::isGrp03(cw.disp);
  assign grp07En = cramPkg::isGrp07(cw.disp);
  assign grp37En = cramPkg::isGrp37(cw.disp);

  // DISP 03 is the return
  assign returnStrobe = cw.disp == cramPkg::dispGrp03;

  assign condSel = cw.cond[2:0];
  assign skip40En = cw.cond[cramPkg::condWidth-1 -: 3] == cramPkg::skipGrp40;
  assign skip50En = cw.cond[cramPkg::condWidth-1 -: 3] == cramPkg::skipGrp50;

  // Doubled so every selector gets a full 4-bit slice
  assign condFlagsWrap = {condFlags, condFlags};

  ////////////////////////////////////////////////////////////
  // Dispatch term
  ////////////////////////////////////////////////////////////

  // High part, only for DISP 00-03
  always_comb begin
    hiTerm = '0;
    if (grp03En) begin
      case (cw.disp[1:0])
        2'd0: hiTerm = diagAdr[cramPkg::adrWidth-1:cramPkg::srcWidth];
        2'd1: begin
          // DRAM J is used only for a zero A field
          if (dramA == '0) begin
            hiTerm = dramJ[cramPkg::adrWidth-1:cramPkg::srcWidth];
          end
        end
        2'd2: hiTerm = '0;
        default: hiTerm = sbrRet[cramPkg::adrWidth-1:cramPkg::srcWidth];
      endcase
    end
  end

  // Low four bits; DISP 00-03 also land here so the whole address follows
  always_comb begin
    loTerm = '0;
    if (grp07En) begin
      case (cw.disp[2:0])
        3'd0: loTerm = diagAdr[cramPkg::srcWidth-1:0];
        3'd1: loTerm = dramJ[cramPkg::srcWidth-1:0];
        3'd2: loTerm = '0;
        3'd3: loTerm = sbrRet[cramPkg::srcWidth-1:0];
        3'd4: loTerm = pfDisp;
        3'd5: loTerm = sr;
        3'd6: loTerm = niCond;
        default: loTerm = shmSh;
      endcase
    end else if (grp37En) begin
      loTerm = condFlagsWrap[cw.disp[2:0] +: cramPkg::srcWidth];
    end
  end

  // Skip groups only touch address bit 0
  always_comb begin
    skipBit = 1'b0;
    if (skip40En) begin
      skipBit = condFlags[condSel];
    end else if (skip50En) begin
      skipBit = ~condFlags[condSel];
    end
  end

  assign dispTerm = {hiTerm, loTerm} | {{(cramPkg::adrWidth-1){1'b0}}, skipBit};
  assign forceTerm = force1777 ? cramPkg::force1777Adr : '0;

  ////////////////////////////////////////////////////////////
  // Next address register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      cradr <= '0;
    end else begin
      cradr <= cw.j | forceTerm | dispTerm;
    end
  end

  // Parity over the fields the diagnostic can read back
  assign dispParity = ^{cw.call, cw.disp};

endmodule

// File: hw/sbrStack.sv
`timescale 1ns/1ps

module sbrStack (
  input  logic                                  eboxClk,
  input  logic                                  rstN,
  iCramWord.stack                               cw,
  input  logic                                  force1777,
  input  logic                                  returnStrobe,
  input  cramPkg::cradrT                        cradr,
  output cramPkg::cradrT                        sbrRet,
  output logic [cramPkg::stackPtrWidth-1:0]     stackPtr
);

  cramPkg::cradrT stackMem [cramPkg::stackDepth];

  logic pushEn;
  logic popEn;
  logic reloadEn;
  logic [cramPkg::stackPtrWidth-1:0] popIdx;

  ////////////////////////////////////////////////////////////
  // Stack operations
  ////////////////////////////////////////////////////////////

  // Force 1777 pushes like a call and cancels a return
  assign pushEn = rstN & (cw.call | force1777);
  assign popEn = rstN & returnStrobe & ~force1777;
  assign reloadEn = pushEn & popEn;

  // Entry that becomes top after a pop
  assign popIdx = stackPtr - 2'd2;

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      stackPtr <= '0;
    end else if (reloadEn) begin
      stackPtr <= '0;
    end else if (pushEn) begin
      stackPtr <= stackPtr + 1'b1;
    end else if (popEn) begin
      stackPtr <= stackPtr - 1'b1;
    end
  end

  // Pointer wraps, so the oldest entry is overwritten after 16 calls
  always_ff @(posedge eboxClk) begin
    if (pushEn && !popEn) begin
      stackMem[stackPtr] <= cradr;
    end
  end

  ////////////////////////////////////////////////////////////
  // Return address, always the entry at pointer minus one
  ////////////////////////////////////////////////////////////

  always_ff @(posedge eboxClk) begin
    if (reloadEn) begin
      // Pointer reloads to zero, so the top is the last entry
      sbrRet <= stackMem[cramPkg::stackDepth-1];
    end else if (pushEn) begin
      sbrRet <= cradr;    // New top is the value being pushed
    end else if (popEn) begin
      sbrRet <= stackMem[popIdx];
    end
  end

endmodule

// File: hw/craDiag.sv
`timescale 1ns/1ps

module craDiag (
  input  logic                                  eboxClk,
  input  logic                                  rstN,
  iCramWord.diag                                cw,
  input  ebusPkg::diagStrobeT                   diagStrobe,
  input  logic                                  diagRead,
  input  ebusPkg::diagFuncT                     diagFunc,
  input  logic [ebusPkg::ebusWidth-1:0]         ebusIn,
  input  cramPkg::cradrT                        cradr,
  input  cramPkg::cradrT                        sbrRet,
  input  logic [cramPkg::stackPtrWidth-1:0]     stackPtr,
  input  logic                                  dispParity,
  output cramPkg::cradrT                        diagAdr,
  output logic [ebusPkg::ebusWidth-1:0]         ebusOut,
  output logic                                  ebusDriving
);

  logic [ebusPkg::ebusWidth-1:0] readWord;
  logic [cramPkg::adrWidth-ebusPkg::ebusWidth-1:0] adrHigh;
  logic [cramPkg::adrWidth-ebusPkg::ebusWidth-1:0] retHigh;

  ////////////////////////////////////////////////////////////
  // Diagnostic address register
  ////////////////////////////////////////////////////////////

  // Low strobe takes all six data bits, high strobe the low five
  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      diagAdr <= '0;
    end else if (diagStrobe == ebusPkg::diagLoadLow) begin
      diagAdr[ebusPkg::ebusWidth-1:0] <= ebusIn;
    end else if (diagStrobe == ebusPkg::diagLoadHigh) begin
      diagAdr[cramPkg::adrWidth-1:ebusPkg::ebusWidth] <= ebusIn[$bits(adrHigh)-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////

  assign adrHigh = cradr[cramPkg::adrWidth-1:ebusPkg::ebusWidth];
  assign retHigh = sbrRet[cramPkg::adrWidth-1:ebusPkg::ebusWidth];

  always_comb begin
    case (diagFunc)
      ebusPkg::diagRdDecode: begin
        readWord = {cramPkg::isGrp07(cw.disp), cramPkg::isGrp03(cw.disp), stackPtr};
      end
      ebusPkg::diagRdCall: readWord = {cw.call, cw.disp};
      ebusPkg::diagRdRetLow: readWord = sbrRet[ebusPkg::ebusWidth-1:0];
      ebusPkg::diagRdRetHigh: readWord = {cramPkg::isGrp37(cw.disp), retHigh};
      // Low half of CRADR answers at two codes
      ebusPkg::diagRdAdrLow, ebusPkg::diagRdAdrLowAlt: begin
        readWord = cradr[ebusPkg::ebusWidth-1:0];
      end
      ebusPkg::diagRdParity: readWord = {dispParity, adrHigh};
      default: readWord = {1'b0, adrHigh};
    endcase
  end

  // Bus slice is zero whenever another board owns it
  assign ebusOut = diagRead ? readWord : '0;
  assign ebusDriving = diagRead;

endmodule

// File: hw/craTop.sv
`timescale 1ns/1ps

module craTop (
  input  logic                                  eboxClk,
  input  logic                                  rstN,

  // Microword fields
  input  cramPkg::cradrT                        j,
  input  logic [cramPkg::dispWidth-1:0]         disp,
  input  logic [cramPkg::condWidth-1:0]         cond,
  input  logic                                  call,
  input  logic                                  force1777,

  // Dispatch sources
  input  logic [cramPkg::dramAWidth-1:0]        dramA,
  input  cramPkg::cradrT                        dramJ,
  input  logic [cramPkg::srcWidth-1:0]          pfDisp,
  input  logic [cramPkg::srcWidth-1:0]          sr,
  input  logic [cramPkg::srcWidth-1:0]          niCond,
  input  logic [cramPkg::srcWidth-1:0]          shmSh,
  input  logic [cramPkg::condFlagWidth-1:0]     condFlags,

  // Diagnostic access
  input  ebusPkg::diagStrobeT                   diagStrobe,
  input  logic                                  diagRead,
  input  ebusPkg::diagFuncT                     diagFunc,
  input  logic [ebusPkg::ebusWidth-1:0]         ebusIn,

  output cramPkg::cradrT                        cradr,
  output logic [ebusPkg::ebusWidth-1:0]         ebusOut,
  output logic                                  ebusDriving
);

  logic returnStrobe;
  logic dispParity;
  cramPkg::cradrT sbrRet;
  cramPkg::cradrT diagAdr;
  logic [cramPkg::stackPtrWidth-1:0] stackPtr;

  iCramWord cw ();

  assign cw.j = j;
  assign cw.disp = disp;
  assign cw.cond = cond;
  assign cw.call = call;

  ////////////////////////////////////////////////////////////
  // Dispatcher, stack and diagnostic readback
  ////////////////////////////////////////////////////////////

  craDispatch i_craDispatch (
    .eboxClk(eboxClk), .rstN(rstN), .cw(cw.dispatch), .force1777(force1777),
    .dramA(dramA), .dramJ(dramJ), .pfDisp(pfDisp), .sr(sr), .niCond(niCond),
    .shmSh(shmSh), .condFlags(condFlags), .diagAdr(diagAdr), .sbrRet(sbrRet),
    .cradr(cradr), .returnStrobe(returnStrobe), .dispParity(dispParity)
  );

  sbrStack i_sbrStack (
    .eboxClk(eboxClk), .rstN(rstN), .cw(cw.stack), .force1777(force1777),
    .returnStrobe(returnStrobe), .cradr(cradr), .sbrRet(sbrRet), .stackPtr(stackPtr)
  );

  craDiag i_craDiag (
    .eboxClk(eboxClk), .rstN(rstN), .cw(cw.diag), .diagStrobe(diagStrobe),
    .diagRead(diagRead), .diagFunc(diagFunc), .ebusIn(ebusIn), .cradr(cradr),
    .sbrRet(sbrRet), .stackPtr(stackPtr), .dispParity(dispParity),
    .diagAdr(diagAdr), .ebusOut(ebusOut), .ebusDriving(ebusDriving)
  );

endmodule

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic eboxClk,
  output logic rstN
);

  initial begin
    eboxClk = 1'b0;
    forever #10 eboxClk = ~eboxClk;
  end

  // Reset held for ten cycles, released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (10) @(posedge eboxClk);
    @(negedge eboxClk);
    rstN = 1'b1;
  end

endmodule

// File: include/craTbVectors.svh
`ifndef CRA_TB_VECTORS_SVH
`define CRA_TB_VECTORS_SVH

// addRow columns: test, j, disp, cond, call, force1777, condFlags, expected cradr
// addDiagRow columns: test, j, disp, strobe, read, func, ebusIn, expected cradr, expected ebus
// Fixed sources: dramA 0, dramJ 2b7, pfDisp 5, sr a, niCond 3, shmSh c

task automatic loadVectors();
  // Plain jumps and force 1777
  addRow(2, 11'h123, 5'o10, 6'o00, 1'b0, 1'b0, 8'h00, 11'h123);
  addRow(2, 11'h055, 5'o10, 6'o00, 1'b0, 1'b0, 8'h00, 11'h055);
  addRow(2, 11'h000, 5'o10, 6'o00, 1'b0, 1'b1, 8'h00, 11'h7ff);
  addRow(2, 11'h400, 5'o10, 6'o00, 1'b0, 1'b0, 8'h00, 11'h400);
  // DISP 00-07, stack top holds 055 from the force push
  addRow(3, 11'h100, 5'o00, 6'o00, 1'b0, 1'b0, 8'h00, 11'h100);
  addRow(3, 11'h100, 5'o01, 6'o00, 1'b0, 1'b0, 8'h00, 11'h3b7);
  addRow(3, 11'h100, 5'o02, 6'o00, 1'b0, 1'b0, 8'h00, 11'h100);
  addRow(3, 11'h100, 5'o03, 6'o00, 1'b0, 1'b0, 8'h00, 11'h155);
  addRow(3, 11'h100, 5'o04, 6'o00, 1'b0, 1'b0, 8'h00, 11'h105);
  addRow(3, 11'h100, 5'o05, 6'o00, 1'b0, 1'b0, 8'h00, 11'h10a);
  addRow(3, 11'h100, 5'o06, 6'o00, 1'b0, 1'b0, 8'h00, 11'h103);
  addRow(3, 11'h100, 5'o07, 6'o00, 1'b0, 1'b0, 8'h00, 11'h10c);
  // DISP 30-37, four flags starting at the selected bit, wrapping
  addRow(3, 11'h000, 5'o30, 6'o00, 1'b0, 1'b0, 8'hb6, 11'h006);
  addRow(3, 11'h000, 5'o31, 6'o00, 1'b0, 1'b0, 8'hb6, 11'h00b);
  addRow(3, 11'h000, 5'o32, 6'o00, 1'b0, 1'b0, 8'hb6, 11'h00d);
  addRow(3, 11'h000, 5'o33, 6'o00, 1'b0, 1'b0, 8'hb6, 11'h006);
  addRow(3, 11'h000, 5'o34, 6'o00, 1'b0, 1'b0, 8'hb6, 11'h00b);
  addRow(3, 11'h000, 5'o35, 6'o00, 1'b0, 1'b0, 8'hb6, 11'h005);
  addRow(3, 11'h000, 5'o36, 6'o00, 1'b0, 1'b0, 8'hb6, 11'h00a);
  addRow(3, 11'h000, 5'o37, 6'o00, 1'b0, 1'b0, 8'hb6, 11'h00d);
  // Single call and return, then two nested levels
  addRow(5, 11'h200, 5'o10, 6'o00, 1'b0, 1'b0, 8'h00, 11'h200);
  addRow(5, 11'h300, 5'o10, 6'o00, 1'b1, 1'b0, 8'h00, 11'h300);
  addRow(5, 11'h000, 5'o03, 6'o00, 1'b0, 1'b0, 8'h00, 11'h200);
  addRow(5, 11'h011, 5'o10, 6'o00, 1'b0, 1'b0, 8'h00, 11'h011);
  addRow(5, 11'h022, 5'o10, 6'o00, 1'b1, 1'b0, 8'h00, 11'h022);
  addRow(5, 11'h044, 5'o10, 6'o00, 1'b1, 1'b0, 8'h00, 11'h044);
  addRow(5, 11'h000, 5'o03, 6'o00, 1'b0, 1'b0, 8'h00, 11'h022);
  addRow(5, 11'h000, 5'o03, 6'o00, 1'b0, 1'b0, 8'h00, 11'h011);
  // Diagnostic address load, dispatch through it, read CRADR back
  addDiagRow(6, 11'h000, 5'o10, 2'b01, 1'b0, 3'd0, 6'h2a, 11'h000, 6'h00);
  addDiagRow(6, 11'h000, 5'o10, 2'b10, 1'b0, 3'd0, 6'h15, 11'h000, 6'h00);
  addDiagRow(6, 11'h000, 5'o00, 2'b00, 1'b0, 3'd0, 6'h00, 11'h56a, 6'h00);
  addDiagRow(6, 11'h56a, 5'o10, 2'b00, 1'b1, 3'd4, 6'h00, 11'h56a, 6'h2a);
  addDiagRow(6, 11'h56a, 5'o10, 2'b00, 1'b1, 3'd7, 6'h00, 11'h56a, 6'h15);
  addDiagRow(6, 11'h56a, 5'o10, 2'b00, 1'b1, 3'd5, 6'h00, 11'h56a, 6'h35);
endtask

`endif

// File: test/craTb.sv
`timescale 1ns/1ps

module craTb;

  typedef struct packed {
    logic [3:0] testId;
    cramPkg::cradrT j;
    logic [4:0] disp;
    logic [5:0] cond;
    logic call;
    logic frc;
    logic [7:0] condFlags;
    logic [1:0] strobe;
    logic rd;
    logic [2:0] func;
    logic [5:0] ebusIn;
    cramPkg::cradrT expCradr;
    logic [5:0] expEbus;
  } vecT;

  logic eboxClk;
  logic rstN;
  cramPkg::cradrT j;
  cramPkg::cradrT dramJ;
  cramPkg::cradrT cradr;
  logic [4:0] disp;
  logic [5:0] cond;
  logic call;
  logic force1777;
  logic [2:0] dramA;
  logic [3:0] pfDisp;
  logic [3:0] sr;
  logic [3:0] niCond;
  logic [3:0] shmSh;
  logic [7:0] condFlags;
  logic [1:0] diagStrobe;
  logic diagRead;
  logic [2:0] diagFunc;
  logic [5:0] ebusIn;
  logic [5:0] ebusOut;
  logic ebusDriving;

  vecT rows[$];
  int errorCount = 0;
  int checkCount = 0;
  int testCount = 0;

  clockGen i_clockGen (.eboxClk(eboxClk), .rstN(rstN));

  craTop i_craTop (
    .eboxClk(eboxClk), .rstN(rstN), .j(j), .disp(disp), .cond(cond), .call(call),
    .force1777(force1777), .dramA(dramA), .dramJ(dramJ), .pfDisp(pfDisp), .sr(sr),
    .niCond(niCond), .shmSh(shmSh), .condFlags(condFlags), .diagStrobe(diagStrobe),
    .diagRead(diagRead), .diagFunc(diagFunc), .ebusIn(ebusIn), .cradr(cradr),
    .ebusOut(ebusOut), .ebusDriving(ebusDriving)
  );

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
      errorCount++;
    end
  endtask

  task automatic addRow(input int id, input cramPkg::cradrT rj, input logic [4:0] rd,
                        input logic [5:0] rc, input logic rcall, input logic rf,
                        input logic [7:0] flags, input cramPkg::cradrT expAdr);
    rows.push_back(vecT'{id[3:0], rj, rd, rc, rcall, rf, flags, 2'b00, 1'b0, 3'd0,
                         6'h00, expAdr, 6'h00});
  endtask

  task automatic addDiagRow(input int id, input cramPkg::cradrT rj, input logic [4:0] rd,
                            input logic [1:0] stb, input logic rrd, input logic [2:0] fn,
                            input logic [5:0] din, input cramPkg::cradrT expAdr,
                            input logic [5:0] expBus);
    rows.push_back(vecT'{id[3:0], rj, rd, 6'o00, 1'b0, 1'b0, 8'h00, stb, rrd, fn,
                         din, expAdr, expBus});
  endtask

  `include "craTbVectors.svh"

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic driveRow(input vecT r);
    j = r.j;
    disp = r.disp;
    cond = r.cond;
    call = r.call;
    force1777 = r.frc;
    condFlags = r.condFlags;
    diagStrobe = r.strobe;
    diagRead = r.rd;
    diagFunc = r.func;
    ebusIn = r.ebusIn;
  endtask

  //////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////

  initial begin
    int waitCount;
    int startErrors;
    logic [31:0] seed;
    logic flag;
    vecT r;
    r = '0;
    driveRow(r);
    dramA = 3'd0;
    dramJ = 11'h2b7;
    pfDisp = 4'h5;
    sr = 4'ha;
    niCond = 4'h3;
    shmSh = 4'hc;
    loadVectors();

    waitCount = 0;
    while (rstN !== 1'b1 && waitCount < 50) begin
      @(negedge eboxClk);
      waitCount++;
    end
    if (rstN !== 1'b1) begin
      $display("Timed out waiting for reset release");
      $display("Test failures found");
      $finish;
    end else begin
      // Reset state
      checkValue("cradr", cradr, 0);
      checkValue("ebusDriving", ebusDriving, 0);
      testCount++;
      $display("Test 1 finished, errors %0d", errorCount);

      startErrors = errorCount;
      foreach (rows[i]) begin
        driveRow(rows[i]);
        @(posedge eboxClk);
        @(negedge eboxClk);
        checkValue("cradr", cradr, rows[i].expCradr);
        checkValue("ebusOut", ebusOut, rows[i].expEbus);
        checkValue("ebusDriving", ebusDriving, rows[i].rd);
        if (i == rows.size() - 1 || rows[i + 1].testId != rows[i].testId) begin
          testCount++;
          $display("Test %0d finished, errors %0d", rows[i].testId,
                   errorCount - startErrors);
          startErrors = errorCount;
        end
      end

      // Random skips, bit 0 of J kept clear so it shows the flag
      seed = 32'h507b0079;
      r = '0;
      r.disp = 5'o10;
      for (int n = 0; n < 32; n++) begin
        seed = nextRandom(seed);
        r.condFlags = seed[7:0];
        r.cond = {(seed[11] ? 3'o5 : 3'o4), seed[10:8]};
        r.j = {seed[23:14], 1'b0};
        flag = r.condFlags[r.cond[2:0]];
        driveRow(r);
        @(posedge eboxClk);
        @(negedge eboxClk);
        checkValue("cradr", cradr, {r.j[10:1], flag ^ seed[11]});
      end
      testCount++;
      $display("Test 4 finished, errors %0d", errorCount - startErrors);

      $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
      if (errorCount == 0) begin
        $display("All tests passed!");
      end else begin
        $display("Test failures found");
      end
      $finish;
    end
  end

endmodule

// File: flist.f
+incdir+include
hw/cramPkg.sv
hw/ebusPkg.sv
hw/iCramWord.sv
hw/craDispatch.sv
hw/sbrStack.sv
hw/craDiag.sv
hw/craTop.sv
test/clockGen.sv
test/craTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= craTb
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
PASSMSG   := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "$(PASSMSG)"; then \
	  exit 0; \
	else \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJDIR)
